// ==== files.f ====
hw/stack_cpu_pkg.sv
hw/lifo_stack.sv
hw/stack_alu.sv
hw/mem_port.sv
hw/control_fsm.sv
hw/stack_cpu.sv
tb/mem_responder.sv
tb/tb_stack_cpu.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := tb_stack_cpu
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_stack_cpu.sv ====
module tb_stack_cpu import stack_cpu_pkg::*; ();

    localparam int    NUM_ROWS     = 12;
    localparam int    ROW_TIMEOUT  = 400;
    localparam int    RESET_CYCLES = 3;
    localparam int    DRIVE_DELAY  = 2;
    localparam data_t UNDEF        = {5'd31, 11'd0};

    typedef struct packed {
        addr_t addr;
        data_t data;
    } mem_word_t;

    logic        clk = 1'b0;
    logic        reset;
    mem_req_t    imem;
    mem_req_t    dmem;
    logic        imem_ack;
    logic        dmem_ack;
    data_t       imem_rdata;
    data_t       dmem_rdata;
    cpu_status_t status;
    logic        mem_clear;
    logic        imem_load;
    logic        dmem_load;
    addr_t       load_addr;
    data_t       load_data;

    // Program, preload, expected writes and cause per row
    data_t       prog       [NUM_ROWS][$];
    mem_word_t   preloads   [NUM_ROWS][$];
    mem_word_t   exp_writes [NUM_ROWS][$];
    trap_cause_t exp_cause  [NUM_ROWS];

    int row;
    int write_idx;
    int errors;
    int checks;
    int rows_run;
    bit timed_out;

    always #10 clk = ~clk;

    stack_cpu i_dut (
        .clk        (clk),
        .reset      (reset),
        .imem       (imem),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .dmem       (dmem),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata),
        .status     (status)
    );

    mem_responder u_imem (
        .clk       (clk),
        .reset     (reset),
        .clear     (mem_clear),
        .load      (imem_load),
        .load_addr (load_addr),
        .load_data (load_data),
        .bus       (imem),
        .ack       (imem_ack),
        .rdata     (imem_rdata)
    );

    mem_responder u_dmem (
        .clk       (clk),
        .reset     (reset),
        .clear     (mem_clear),
        .load      (dmem_load),
        .load_addr (load_addr),
        .load_data (load_data),
        .bus       (dmem),
        .ack       (dmem_ack),
        .rdata     (dmem_rdata)
    );

    function automatic data_t encode(opcode_t op, int operand);
        return {op, OPERAND_WIDTH'(operand)};
    endfunction

    function automatic mem_word_t mem_word(int addr, int data);
        mem_word_t w;
        w.addr = addr_t'(addr);
        w.data = data_t'(data);
        return w;
    endfunction

    task automatic build_table();
        // In the ALU rows a is the later push and SUB gives 5 minus 7
        prog[0] = '{encode(PUSH_I, 7), encode(PUSH_I, 5), encode(SUB, 0),
                    encode(POP, 3), UNDEF};
        exp_writes[0] = '{mem_word(3, 65534)};
        prog[1] = '{encode(PUSH_I, 7), encode(PUSH_I, 5), encode(ADD, 0),
                    encode(POP, 3), UNDEF};
        exp_writes[1] = '{mem_word(3, 12)};
        prog[2] = '{encode(PUSH_I, 7), encode(PUSH_I, 5), encode(AND, 0),
                    encode(POP, 3), UNDEF};
        exp_writes[2] = '{mem_word(3, 5)};
        prog[3] = '{encode(PUSH_I, 7), encode(PUSH_I, 5), encode(OR, 0),
                    encode(POP, 3), UNDEF};
        exp_writes[3] = '{mem_word(3, 7)};
        prog[4] = '{encode(PUSH_I, 7), encode(PUSH_I, 5), encode(XOR, 0),
                    encode(POP, 3), UNDEF};
        exp_writes[4] = '{mem_word(3, 2)};
        // Memory to memory copy
        prog[5] = '{encode(PUSH, 9), encode(POP, 10), UNDEF};
        preloads[5] = '{mem_word(9, 1234)};
        exp_writes[5] = '{mem_word(10, 1234)};
        // IF_EQ taken on 0 and then not taken on 1
        prog[6] = '{encode(PUSH_I, 0), encode(IF_EQ, 3), UNDEF, encode(PUSH_I, 1),
                    encode(IF_EQ, 8), encode(PUSH_I, 12), encode(POP, 22), UNDEF, UNDEF};
        exp_writes[6] = '{mem_word(22, 12)};
        // IF_LT taken on 0 minus 1 and then not taken on 3
        prog[7] = '{encode(PUSH_I, 1), encode(PUSH_I, 0), encode(SUB, 0),
                    encode(IF_LT, 5), UNDEF, encode(PUSH_I, 3), encode(IF_LT, 10),
                    encode(PUSH_I, 14), encode(POP, 23), UNDEF, UNDEF};
        exp_writes[7] = '{mem_word(23, 14)};
        prog[8] = '{encode(PUSH_I, 15), encode(GOTO, 3), encode(POP, 24),
                    encode(PUSH_I, 16), encode(POP, 25), UNDEF};
        exp_writes[8] = '{mem_word(25, 16)};
        // Subroutine at 4 writes its marker before the caller's
        prog[9] = '{encode(CALL, 4), encode(PUSH_I, 18), encode(POP, 27), UNDEF,
                    encode(PUSH_I, 17), encode(POP, 26), encode(RET, 0)};
        exp_writes[9] = '{mem_word(26, 17), mem_word(27, 18)};
        prog[10] = '{encode(POP, 5)};
        // Loop pushes until the 17th push overflows
        prog[11] = '{encode(PUSH_I, 1), encode(GOTO, 0)};
        for (int r = 0; r < 10; r++) begin
            exp_cause[r] = CAUSE_ILLEGAL;
        end
        exp_cause[10] = CAUSE_UNDERFLOW;
        exp_cause[11] = CAUSE_OVERFLOW;
    endtask

    task automatic check_write(addr_t addr, data_t data);
        checks++;
        if (write_idx >= exp_writes[row].size()) begin
            $display("ERROR at %0t: row %0d unexpected write of %0d to address %0d",
                     $time, row, data, addr);
            errors++;
        end else if (addr != exp_writes[row][write_idx].addr ||
                     data != exp_writes[row][write_idx].data) begin
            $display("ERROR at %0t: row %0d write %0d was %0d to %0d, expected %0d to %0d",
                     $time, row, write_idx, data, addr,
                     exp_writes[row][write_idx].data, exp_writes[row][write_idx].addr);
            errors++;
        end
        write_idx++;
    endtask

    // One negedge falls inside each req and ack overlap
    always @(negedge clk) begin
        if (!reset && dmem.req && dmem_ack && dmem.write) begin
            check_write(dmem.addr, dmem.wdata);
        end
        // Instruction fetches are reads only
        if (!reset && imem.req && imem.write) begin
            $display("ERROR at %0t: row %0d wrote to instruction memory", $time, row);
            errors++;
        end
    end

    task automatic run_row(int r);
        int cycles;
        @(posedge clk);
        #DRIVE_DELAY;
        reset     = 1'b1;
        mem_clear = 1'b1;
        row       = r;
        write_idx = 0;
        @(posedge clk);
        #DRIVE_DELAY;
        mem_clear = 1'b0;
        for (int i = 0; i < prog[r].size(); i++) begin
            imem_load = 1'b1;
            load_addr = addr_t'(i);
            load_data = prog[r][i];
            @(posedge clk);
            #DRIVE_DELAY;
        end
        imem_load = 1'b0;
        for (int i = 0; i < preloads[r].size(); i++) begin
            dmem_load = 1'b1;
            load_addr = preloads[r][i].addr;
            load_data = preloads[r][i].data;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        dmem_load = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        rows_run++;

        cycles = 0;
        while (!status.halted && cycles < ROW_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!status.halted) begin
            $display("Row %0d: the program never halted within %0d cycles", r, ROW_TIMEOUT);
            timed_out = 1'b1;
        end else begin
            checks++;
            if (status.cause != exp_cause[r]) begin
                $display("ERROR at %0t: row %0d halted with cause %0d, expected %0d",
                         $time, r, status.cause, exp_cause[r]);
                errors++;
            end
            // Halted core stays off both buses
            repeat (4) begin
                @(negedge clk);
                checks++;
                if (imem.req || dmem.req) begin
                    $display("ERROR at %0t: row %0d issued a request after halting",
                             $time, r);
                    errors++;
                end
            end
            checks++;
            if (write_idx != exp_writes[r].size()) begin
                $display("ERROR at %0t: row %0d made %0d data writes, expected %0d",
                         $time, r, write_idx, exp_writes[r].size());
                errors++;
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        mem_clear = 1'b0;
        imem_load = 1'b0;
        dmem_load = 1'b0;
        load_addr = '0;
        load_data = '0;
        row       = 0;
        write_idx = 0;
        errors    = 0;
        checks    = 0;
        rows_run  = 0;
        timed_out = 1'b0;
        build_table();
        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            run_row(r);
        end
        $display("Summary: %0d rows run, %0d checks, %0d errors, %0d timeouts",
                 rows_run, checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tb/mem_responder.sv ====
module mem_responder import stack_cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     clear,
    input  logic     load,
    input  addr_t    load_addr,
    input  data_t    load_data,
    input  mem_req_t bus,
    output logic     ack,
    output data_t    rdata
);

    localparam int WORDS = 2 ** ADDR_WIDTH;

    data_t  mem [WORDS];
    integer seed = 32'hc0154af6;
    int     wait_cycles;
    logic   in_reset;

    initial begin
        ack         = 1'b0;
        rdata       = '0;
        wait_cycles = 0;
        forever begin
            @(posedge clk);
            // Testbench controls are sampled at the edge
            in_reset = reset;
            if (clear) begin
                // Opcode 31 everywhere, so a runaway program traps
                for (int i = 0; i < WORDS; i++) begin
                    mem[i] = {5'h1f, 3'b000, addr_t'(i)};
                end
            end
            if (load) begin
                mem[load_addr] = load_data;
            end
            #1;
            if (in_reset) begin
                ack         = 1'b0;
                wait_cycles = 0;
            end else if (!ack && bus.req) begin
                if (wait_cycles == 0) begin
                    ack = 1'b1;
                    if (bus.write) begin
                        mem[bus.addr] = bus.wdata;
                    end else begin
                        rdata = mem[bus.addr];
                    end
                    // Delay for the next request, 0 to 3 cycles
                    wait_cycles = $random(seed) & 3;
                end else begin
                    wait_cycles = wait_cycles - 1;
                end
            end else if (ack && !bus.req) begin
                ack = 1'b0;
            end
        end
    end

endmodule

// ==== hw/stack_cpu.sv ====
module stack_cpu import stack_cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    output mem_req_t    imem,
    input  logic        imem_ack,
    input  data_t       imem_rdata,
    output mem_req_t    dmem,
    input  logic        dmem_ack,
    input  data_t       dmem_rdata,
    output cpu_status_t status
);

    logic     ifetch_start;
    logic     ifetch_done;
    mem_cmd_t ifetch_cmd;
    data_t    ifetch_data;
    logic     data_start;
    logic     data_done;
    mem_cmd_t data_cmd;
    data_t    data_rdata;
    logic     opnd_push;
    logic     opnd_pop;
    data_t    opnd_wdata;
    data_t    opnd_top;
    logic     opnd_full;
    logic     opnd_empty;
    logic     ret_push;
    logic     ret_pop;
    data_t    ret_wdata;
    data_t    ret_top;
    logic     ret_full;
    logic     ret_empty;
    alu_op_t  alu_op;
    data_t    alu_a;
    data_t    alu_b;
    data_t    alu_result;

    control_fsm u_control (
        .clk          (clk),
        .reset        (reset),
        .ifetch_start (ifetch_start),
        .ifetch_cmd   (ifetch_cmd),
        .ifetch_done  (ifetch_done),
        .ifetch_data  (ifetch_data),
        .data_start   (data_start),
        .data_cmd     (data_cmd),
        .data_done    (data_done),
        .data_rdata   (data_rdata),
        .opnd_push    (opnd_push),
        .opnd_pop     (opnd_pop),
        .opnd_wdata   (opnd_wdata),
        .opnd_top     (opnd_top),
        .opnd_full    (opnd_full),
        .opnd_empty   (opnd_empty),
        .ret_push     (ret_push),
        .ret_pop      (ret_pop),
        .ret_wdata    (ret_wdata),
        .ret_top      (ret_top),
        .ret_full     (ret_full),
        .ret_empty    (ret_empty),
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_result   (alu_result),
        .status       (status)
    );

    lifo_stack #(.DEPTH(OPERAND_DEPTH)) u_operand_stack (
        .clk   (clk),
        .reset (reset),
        .push  (opnd_push),
        .pop   (opnd_pop),
        .wdata (opnd_wdata),
        .top   (opnd_top),
        .full  (opnd_full),
        .empty (opnd_empty)
    );

    // Return addresses
    lifo_stack #(.DEPTH(RETURN_DEPTH)) u_return_stack (
        .clk   (clk),
        .reset (reset),
        .push  (ret_push),
        .pop   (ret_pop),
        .wdata (ret_wdata),
        .top   (ret_top),
        .full  (ret_full),
        .empty (ret_empty)
    );

    stack_alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    mem_port u_imem_port (
        .clk       (clk),
        .reset     (reset),
        .start     (ifetch_start),
        .cmd       (ifetch_cmd),
        .done      (ifetch_done),
        .rdata     (ifetch_data),
        .bus       (imem),
        .ack       (imem_ack),
        .bus_rdata (imem_rdata)
    );

    mem_port u_dmem_port (
        .clk       (clk),
        .reset     (reset),
        .start     (data_start),
        .cmd       (data_cmd),
        .done      (data_done),
        .rdata     (data_rdata),
        .bus       (dmem),
        .ack       (dmem_ack),
        .bus_rdata (dmem_rdata)
    );

endmodule

// ==== hw/control_fsm.sv ====
module control_fsm import stack_cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic        ifetch_start,
    output mem_cmd_t    ifetch_cmd,
    input  logic        ifetch_done,
    input  data_t       ifetch_data,
    output logic        data_start,
    output mem_cmd_t    data_cmd,
    input  logic        data_done,
    input  data_t       data_rdata,
    output logic        opnd_push,
    output logic        opnd_pop,
    output data_t       opnd_wdata,
    input  data_t       opnd_top,
    input  logic        opnd_full,
    input  logic        opnd_empty,
    output logic        ret_push,
    output logic        ret_pop,
    output data_t       ret_wdata,
    input  data_t       ret_top,
    input  logic        ret_full,
    input  logic        ret_empty,
    output alu_op_t     alu_op,
    output data_t       alu_a,
    output data_t       alu_b,
    input  data_t       alu_result,
    output cpu_status_t status
);

    cpu_state_t               state;
    addr_t                    pc;
    addr_t                    pc_plus1;
    addr_t                    target;
    data_t                    ir;
    data_t                    temp_a;
    data_t                    temp_b;
    opcode_t                  opcode;
    logic [OPERAND_WIDTH-1:0] operand;
    logic                     taken;
    logic                     trap;
    trap_cause_t              trap_cause;

    assign opcode   = opcode_t'(ir[DATA_WIDTH-1 -: OPCODE_WIDTH]);
    assign operand  = ir[OPERAND_WIDTH-1:0];
    assign target   = operand[ADDR_WIDTH-1:0];
    assign pc_plus1 = pc + 1'b1;

    assign ifetch_cmd = '{write: 1'b0, addr: pc, wdata: '0};

    assign alu_a = temp_a;
    assign alu_b = temp_b;

    always_comb begin
        case (opcode)
            SUB:     alu_op = ALU_SUB;
            AND:     alu_op = ALU_AND;
            OR:      alu_op = ALU_OR;
            XOR:     alu_op = ALU_XOR;
            default: alu_op = ALU_ADD;
        endcase
    end

    // IF_LT tests the sign bit
    assign taken = (opcode == IF_EQ) ? (opnd_top == '0) : opnd_top[DATA_WIDTH-1];

    // Stack strobes and trap detection
    always_comb begin
        opnd_push  = 1'b0;
        opnd_pop   = 1'b0;
        opnd_wdata = alu_result;
        ret_push   = 1'b0;
        ret_pop    = 1'b0;
        ret_wdata  = data_t'(pc_plus1);
        trap       = 1'b0;
        trap_cause = CAUSE_NONE;
        case (state)
            DECODE: begin
                case (opcode)
                    PUSH_I: begin
                        opnd_wdata = data_t'(operand);
                        opnd_push  = !opnd_full;
                        trap       = opnd_full;
                        trap_cause = CAUSE_OVERFLOW;
                    end
                    PUSH: begin
                        // Push itself happens once the read returns
                        trap       = opnd_full;
                        trap_cause = CAUSE_OVERFLOW;
                    end
                    POP, ADD, SUB, AND, OR, XOR, IF_EQ, IF_LT: begin
                        opnd_pop   = !opnd_empty;
                        trap       = opnd_empty;
                        trap_cause = CAUSE_UNDERFLOW;
                    end
                    CALL: begin
                        ret_push   = !ret_full;
                        trap       = ret_full;
                        trap_cause = CAUSE_OVERFLOW;
                    end
                    RET: begin
                        ret_pop    = !ret_empty;
                        trap       = ret_empty;
                        trap_cause = CAUSE_UNDERFLOW;
                    end
                    GOTO: begin
                        trap = 1'b0;
                    end
                    default: begin
                        trap       = 1'b1;
                        trap_cause = CAUSE_ILLEGAL;
                    end
                endcase
            end
            LOAD_B: begin
                // Second operand, so an ALU op needs two entries
                opnd_pop   = !opnd_empty;
                trap       = opnd_empty;
                trap_cause = CAUSE_UNDERFLOW;
            end
            EXECUTE: begin
                opnd_push  = !opnd_full;
                trap       = opnd_full;
                trap_cause = CAUSE_OVERFLOW;
            end
            WAIT_DATA: begin
                opnd_wdata = data_rdata;
                opnd_push  = data_done && !data_cmd.write;
            end
            default: begin
                trap = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= FETCH;
            pc           <= '0;
            ifetch_start <= 1'b0;
            data_start   <= 1'b0;
            status       <= '{halted: 1'b0, cause: CAUSE_NONE};
        end else begin
            ifetch_start <= 1'b0;
            data_start   <= 1'b0;
            if (trap) begin
                state  <= HALTED;
                status <= '{halted: 1'b1, cause: trap_cause};
            end else begin
                case (state)
                    FETCH: begin
                        ifetch_start <= 1'b1;
                        state        <= WAIT_FETCH;
                    end
                    WAIT_FETCH: begin
                        if (ifetch_done) begin
                            state <= DECODE;
                        end
                    end
                    DECODE: begin
                        state <= FETCH;
                        case (opcode)
                            PUSH, POP: begin
                                data_start <= 1'b1;
                                state      <= WAIT_DATA;
                            end
                            ADD, SUB, AND, OR, XOR: begin
                                state <= LOAD_B;
                            end
                            GOTO, CALL: begin
                                pc <= target;
                            end
                            IF_EQ, IF_LT: begin
                                pc <= taken ? target : pc_plus1;
                            end
                            RET: begin
                                pc <= ret_top[ADDR_WIDTH-1:0];
                            end
                            default: begin
                                pc <= pc_plus1;
                            end
                        endcase
                    end
                    LOAD_B: begin
                        state <= EXECUTE;
                    end
                    EXECUTE: begin
                        pc    <= pc_plus1;
                        state <= FETCH;
                    end
                    WAIT_DATA: begin
                        if (data_done) begin
                            pc    <= pc_plus1;
                            state <= FETCH;
                        end
                    end
                    default: begin
                        state <= HALTED;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT_FETCH && ifetch_done) begin
            ir <= ifetch_data;
        end
        if (state == DECODE) begin
            temp_a   <= opnd_top;
            data_cmd <= '{write: (opcode == POP), addr: target, wdata: opnd_top};
        end
        if (state == LOAD_B) begin
            temp_b <= opnd_top;
        end
    end

    a_strobes: assert property (@(posedge clk) disable iff (reset)
        !(opnd_push && opnd_pop) && !(ret_push && ret_pop));

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {FETCH, WAIT_FETCH, DECODE, LOAD_B, EXECUTE, WAIT_DATA, HALTED});

endmodule

// ==== hw/mem_port.sv ====
module mem_port import stack_cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  mem_cmd_t cmd,
    output logic     done,
    output data_t    rdata,
    output mem_req_t bus,
    input  logic     ack,
    input  data_t    bus_rdata
);

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_REQ,
        PORT_RELEASE
    } port_state_t;

    port_state_t state;
    mem_cmd_t    cmd_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= PORT_IDLE;
        end else begin
            case (state)
                PORT_IDLE: begin
                    if (start) begin
                        state <= PORT_REQ;
                    end
                end
                PORT_REQ: begin
                    if (ack) begin
                        state <= PORT_RELEASE;
                    end
                end
                PORT_RELEASE: begin
                    // Wait for the memory to drop ack
                    if (!ack) begin
                        state <= PORT_IDLE;
                    end
                end
                default: begin
                    state <= PORT_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == PORT_IDLE && start) begin
            cmd_q <= cmd;
        end
        if (state == PORT_REQ && ack) begin
            rdata <= bus_rdata;
        end
    end

    assign bus.req   = (state == PORT_REQ);
    assign bus.write = cmd_q.write;
    assign bus.addr  = cmd_q.addr;
    assign bus.wdata = cmd_q.wdata;

    assign done = (state == PORT_RELEASE) && !ack;

    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> state == PORT_IDLE);

    a_bus_stable: assert property (@(posedge clk) disable iff (reset)
        (bus.req && !ack) |=> $stable(bus));

endmodule

// ==== hw/stack_alu.sv ====
module stack_alu import stack_cpu_pkg::*; (
    input  alu_op_t op,
    input  data_t   a,
    input  data_t   b,
    output data_t   result
);

    // a is the popped top, b the entry below it
    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                // Wraps modulo 2**16
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== hw/lifo_stack.sv ====
module lifo_stack import stack_cpu_pkg::*; #(
    parameter int DEPTH = OPERAND_DEPTH
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  logic  pop,
    input  data_t wdata,
    output data_t top,
    output logic  full,
    output logic  empty
);

    localparam int IDX_WIDTH = $clog2(DEPTH);
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    data_t                entries [DEPTH];
    logic [CNT_WIDTH-1:0] count;
    logic [IDX_WIDTH-1:0] top_idx;

    assign full  = (count == CNT_WIDTH'(DEPTH));
    assign empty = (count == '0);

    // Entry just below the count, meaningless while empty
    assign top_idx = IDX_WIDTH'(count - 1'b1);
    assign top     = entries[top_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (push && !full) begin
            count <= count + 1'b1;
        end else if (pop && !empty) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full) begin
            entries[count[IDX_WIDTH-1:0]] <= wdata;
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        push |-> !full);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(push && pop));

endmodule

// ==== hw/stack_cpu_pkg.sv ====
package stack_cpu_pkg;

    localparam int DATA_WIDTH    = 16;
    localparam int OPCODE_WIDTH  = 5;
    localparam int OPERAND_WIDTH = 11;
    localparam int ADDR_WIDTH    = 8;
    localparam int OPERAND_DEPTH = 16;
    localparam int RETURN_DEPTH  = 8;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Encoding gaps are undefined and trap
    typedef enum logic [OPCODE_WIDTH-1:0] {
        PUSH   = 5'd0,
        PUSH_I = 5'd1,
        POP    = 5'd3,
        ADD    = 5'd4,
        SUB    = 5'd5,
        AND    = 5'd8,
        OR     = 5'd10,
        XOR    = 5'd11,
        GOTO   = 5'd14,
        IF_EQ  = 5'd15,
        IF_LT  = 5'd17,
        CALL   = 5'd20,
        RET    = 5'd21
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef enum logic [3:0] {
        FETCH,
        WAIT_FETCH,
        DECODE,
        LOAD_B,
        EXECUTE,
        WAIT_DATA,
        HALTED
    } cpu_state_t;

    typedef enum logic [1:0] {
        CAUSE_NONE,
        CAUSE_ILLEGAL,
        CAUSE_OVERFLOW,
        CAUSE_UNDERFLOW
    } trap_cause_t;

    typedef struct packed {
        logic  req;
        logic  write;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // One transaction handed from the controller to a port
    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
    } mem_cmd_t;

    typedef struct packed {
        logic        halted;
        trap_cause_t cause;
    } cpu_status_t;

endpackage
